/* src/rst_mgr_pkg.sv */
package rst_mgr_pkg;

  // widest supported domain vector
  // struct vectors are sized by this, unused upper bits stay zero
  parameter int MaxDomains = 8;

  // bits needed to index any domain
  parameter int DomainIdxW = 3;

  // always-on domain position
  parameter int DomainAonSel = 0;

  // width of the saturating event counter
  parameter int CountW = 8;

  // software command opcodes
  typedef enum logic [1:0] {
    // idle strobe, nothing to do
    op_nop        = 2'd0,
    // hold the indexed domain in reset
    op_assert     = 2'd1,
    // drop the software hold
    op_release    = 2'd2,
    // wipe cause flags and counter
    op_clear_info = 2'd3
  } rst_op_e;

  // decoded request levels from the decode stage
  typedef struct packed {
    // sticky software hold per domain
    logic [MaxDomains-1:0] sw_req;
    // registered hardware request per domain
    logic [MaxDomains-1:0] hw_req;
    // single-cycle clear pulse
    logic                  clear_info;
  } rst_req_t;

  // readback record for software
  typedef struct packed {
    // sticky cause flags
    logic              sw_seen;
    logic              hw_seen;
    logic              parent_seen;
    // number of reset events, stops at all ones
    logic [CountW-1:0] count;
  } rst_info_t;

endpackage

/* src/rst_req_decode.sv */
module rst_req_decode #(
  parameter int PowerDomains = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // command strobe, taken in any cycle it is high
  input  logic                               cmd_valid_i,
  input  rst_mgr_pkg::rst_op_e               cmd_op_i,
  input  logic [rst_mgr_pkg::DomainIdxW-1:0] cmd_domain_i,
  // hardware request levels
  input  logic [PowerDomains-1:0]            hw_req_i,
  output rst_mgr_pkg::rst_req_t              req_o
);

  import rst_mgr_pkg::*;

  // only the implemented domains may ever request
  localparam logic [MaxDomains-1:0] DomMask =
    {MaxDomains{1'b1}} >> (MaxDomains - PowerDomains);

  // registered request struct
  rst_req_t req_q;

  // next values of the three fields
  logic [MaxDomains-1:0] sw_req_d;
  logic [MaxDomains-1:0] hw_req_d;
  logic                  clear_d;

  // strobe points at an existing domain
  logic                  dom_hit;

  // index range check
  // out-of-range indices are dropped silently
  assign dom_hit = cmd_valid_i && (int'(cmd_domain_i) < PowerDomains);

  // software hold update
  always_comb begin
    sw_req_d = req_q.sw_req;
    if (dom_hit) begin
      case (cmd_op_i)
        // repeated assert is harmless, bit is already set
        op_assert:  sw_req_d[cmd_domain_i] = 1'b1;
        op_release: sw_req_d[cmd_domain_i] = 1'b0;
        default:    sw_req_d = req_q.sw_req;
      endcase
    end
  end

  // hardware levels zero-extended to the full vector
  assign hw_req_d = MaxDomains'(hw_req_i);

  // clear ignores the domain index
  assign clear_d = cmd_valid_i && (cmd_op_i == op_clear_info);

  // request register
  // all fields inactive while in reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q <= '0;
    end else begin
      req_q.sw_req     <= sw_req_d & DomMask;
      req_q.hw_req     <= hw_req_d & DomMask;
      // one cycle wide, drops on the next edge
      req_q.clear_info <= clear_d;
    end
  end

  // straight from the flops
  assign req_o = req_q;

endmodule

/* src/rst_domain_ctrl.sv */
module rst_domain_ctrl #(
  parameter int PowerDomains = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // decoded request levels
  input  rst_mgr_pkg::rst_req_t    req_i,
  // parent resets, active low, may be asynchronous
  input  logic [PowerDomains-1:0]  rst_parent_ni,
  // scan bypass
  input  logic                     scanmode_i,
  input  logic                     scan_rst_ni,
  // domain resets after the scan mux
  output logic [PowerDomains-1:0]  rst_no,
  // functional copy before the scan mux
  output logic [PowerDomains-1:0]  dom_rst_no
);

  import rst_mgr_pkg::*;

  // first off domain sits just above the always-on one
  localparam int OffStart = DomainAonSel + 1;

  // two-stage parent synchronizer
  logic [PowerDomains-1:0] parent_meta_q;
  logic [PowerDomains-1:0] parent_sync_q;

  // next reset level per domain
  logic [PowerDomains-1:0] dom_rst_nd;

  // always-on reset flop
  logic                    aon_rst_nq;

  // switched-off domain flops
  logic [PowerDomains-1:OffStart] off_rst_nq;

  // parent sync
  // flops come up as "in reset" so nothing leaks out early
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      parent_meta_q <= '0;
      parent_sync_q <= '0;
    end else begin
      parent_meta_q <= rst_parent_ni;
      parent_sync_q <= parent_meta_q;
    end
  end

  // out of reset only with parent released and no hold of either kind
  assign dom_rst_nd = parent_sync_q &
                      ~req_i.sw_req[PowerDomains-1:0] &
                      ~req_i.hw_req[PowerDomains-1:0];

  // always-on domain
  // only the root reset clears it
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      aon_rst_nq <= 1'b0;
    end else begin
      aon_rst_nq <= dom_rst_nd[DomainAonSel];
    end
  end

  // off domains
  // cleared by root reset or by the always-on flop being low
  // release therefore trails domain 0 by at least one edge
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || !aon_rst_nq) begin
      off_rst_nq <= '0;
    end else begin
      off_rst_nq <= dom_rst_nd[PowerDomains-1:OffStart];
    end
  end

  // functional levels, reassembled in domain order
  assign dom_rst_no[DomainAonSel]            = aon_rst_nq;
  assign dom_rst_no[PowerDomains-1:OffStart] = off_rst_nq;

  // scan mux per bit
  // scan reset goes straight through, no flop in the way
  for (genvar i = 0; i < PowerDomains; i++) begin : gen_scan_mux
    assign rst_no[i] = scanmode_i ? scan_rst_ni : dom_rst_no[i];
  end

endmodule

/* src/rst_info_capture.sv */
module rst_info_capture #(
  parameter int PowerDomains = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // decoded requests as seen by the domain block
  input  rst_mgr_pkg::rst_req_t   req_i,
  // functional domain resets without the scan mux
  input  logic [PowerDomains-1:0] dom_rst_ni,
  output rst_mgr_pkg::rst_info_t  info_o
);

  import rst_mgr_pkg::*;

  // domain levels from the previous cycle
  logic [PowerDomains-1:0] dom_prev_q;

  // requests one cycle back
  // lines up with the fall they caused
  rst_req_t                req_q;

  // readback record
  rst_info_t               info_q;

  // per-domain falls this cycle
  logic [PowerDomains-1:0] fall;

  // cause split per falling domain
  logic [PowerDomains-1:0] sw_cause;
  logic [PowerDomains-1:0] hw_cause;
  logic [PowerDomains-1:0] parent_cause;

  // any fall at all
  logic                    evt;

  // high to low on the functional level
  assign fall = dom_prev_q & ~dom_rst_ni;
  assign evt  = |fall;

  // priority is software then hardware then the parent
  assign sw_cause     = fall & req_q.sw_req[PowerDomains-1:0];
  assign hw_cause     = fall & ~req_q.sw_req[PowerDomains-1:0] &
                        req_q.hw_req[PowerDomains-1:0];
  assign parent_cause = fall & ~req_q.sw_req[PowerDomains-1:0] &
                        ~req_q.hw_req[PowerDomains-1:0];

  // history flops
  // prev starts low so the first release is not an event
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dom_prev_q <= '0;
    end else begin
      dom_prev_q <= dom_rst_ni;
    end
  end

  // request delay line for cause attribution
  always_ff @(posedge clk_i) begin
    req_q <= req_i;
  end

  // record update
  // clear pulse is already one flop late from decode
  // an event on the same edge takes priority
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      info_q <= '0;
    end else if (evt) begin
      info_q.sw_seen     <= info_q.sw_seen | (|sw_cause);
      info_q.hw_seen     <= info_q.hw_seen | (|hw_cause);
      info_q.parent_seen <= info_q.parent_seen | (|parent_cause);
      // stop at all ones
      if (info_q.count != {CountW{1'b1}}) begin
        info_q.count <= info_q.count + 1'b1;
      end
    end else if (req_i.clear_info) begin
      info_q <= '0;
    end
  end

  assign info_o = info_q;

endmodule

/* src/rst_mgr_top.sv */
module rst_mgr_top #(
  // number of implemented domains, 2 up to MaxDomains
  parameter int PowerDomains = 4
) (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  // software command strobe
  input  logic                               cmd_valid_i,
  input  rst_mgr_pkg::rst_op_e               cmd_op_i,
  input  logic [rst_mgr_pkg::DomainIdxW-1:0] cmd_domain_i,
  // hardware request levels
  input  logic [PowerDomains-1:0]            hw_req_i,
  // parent resets, active low
  input  logic [PowerDomains-1:0]            rst_parent_ni,
  // scan bypass controls
  input  logic                               scanmode_i,
  input  logic                               scan_rst_ni,
  // per-domain reset outputs, active low
  output logic [PowerDomains-1:0]            rst_no,
  // cause flags and event count
  output rst_mgr_pkg::rst_info_t             info_o
);

  import rst_mgr_pkg::*;

  // decoded requests, shared by execute and result stages
  rst_req_t                req;

  // functional resets ahead of the scan mux
  logic [PowerDomains-1:0] dom_rst_n;

  // decode stage
  // commands and hardware levels into registered requests
  rst_req_decode #(
    .PowerDomains (PowerDomains)
  ) rst_req_decode_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_op_i     (cmd_op_i),
    .cmd_domain_i (cmd_domain_i),
    .hw_req_i     (hw_req_i),
    .req_o        (req)
  );

  // execute stage
  // parent sync, always-on dependency and scan mux
  rst_domain_ctrl #(
    .PowerDomains  (PowerDomains)
  ) rst_domain_ctrl_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (req),
    .rst_parent_ni (rst_parent_ni),
    .scanmode_i    (scanmode_i),
    .scan_rst_ni   (scan_rst_ni),
    .rst_no        (rst_no),
    .dom_rst_no    (dom_rst_n)
  );

  // result stage
  // watches the functional levels, so scan toggles are not recorded
  rst_info_capture #(
    .PowerDomains (PowerDomains)
  ) rst_info_capture_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (req),
    .dom_rst_ni   (dom_rst_n),
    .info_o       (info_o)
  );

endmodule

/* tb/rst_mgr_properties.sv */
module rst_mgr_properties #(
  parameter int PowerDomains = 4
) (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    scanmode_i,
  input logic                    scan_rst_ni,
  // outputs after the scan mux
  input logic [PowerDomains-1:0] rst_no,
  // functional levels before the scan mux
  input logic [PowerDomains-1:0] dom_rst_no
);
  timeunit 1ns;
  timeprecision 1ps;

  import rst_mgr_pkg::*;

  // every domain except the always-on one
  localparam logic [PowerDomains-1:0] OffMask = ~(PowerDomains'(1) << DomainAonSel);

  // failure tally
  int fail_cnt = 0;

  // domain 0 low in one cycle means all off domains low in the next
  aon_holds_off: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !dom_rst_no[DomainAonSel] |=> ((dom_rst_no & OffMask) == '0)
  ) else begin
    $error("off domain released while always-on domain is in reset");
    fail_cnt++;
  end

  // scan bypass is purely combinational
  scan_bypass: assert property (
    @(posedge clk_i)
    scanmode_i |-> (rst_no == {PowerDomains{scan_rst_ni}})
  ) else begin
    $error("rst_no does not follow scan_rst_ni in scan mode");
    fail_cnt++;
  end

  // root reset clears every domain flop on the next edge
  root_reset_low: assert property (
    @(posedge clk_i)
    !rst_n_i |=> (scanmode_i || (rst_no == '0))
  ) else begin
    $error("domain reset released during root reset");
    fail_cnt++;
  end

endmodule

/* tb/rst_mgr_tb.sv */
module rst_mgr_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import rst_mgr_pkg::*;

  localparam int PowerDomains = 4;
  localparam int ClkPeriod    = 8;
  localparam int ResetCycles  = 5;
  // first phase has no clear commands so the count can saturate
  localparam int SatCycles    = 4000;
  localparam int MixCycles    = 4000;
  localparam int DrainCycles  = 10;
  localparam int TotalCycles  = ResetCycles + SatCycles + MixCycles + DrainCycles;
  localparam int WatchdogNs   = (TotalCycles + 50) * ClkPeriod;
  localparam logic [31:0] Seed = 32'hde33_e2c6;

  // DUT inputs
  logic                    clk = 1'b0;
  logic                    rst_n;
  logic                    cmd_valid;
  rst_op_e                 cmd_op;
  logic [DomainIdxW-1:0]   cmd_domain;
  logic [PowerDomains-1:0] hw_req;
  logic [PowerDomains-1:0] rst_parent_n;
  logic                    scanmode;
  logic                    scan_rst_n;

  // DUT outputs
  logic [PowerDomains-1:0] dut_rst_n;
  rst_info_t               dut_info;

  // reference model state
  logic [PowerDomains-1:0] m_sw;
  logic [PowerDomains-1:0] m_hw;
  logic                    m_clr;
  logic [PowerDomains-1:0] m_meta;
  logic [PowerDomains-1:0] m_sync;
  logic [PowerDomains-1:0] m_dom;
  logic [PowerDomains-1:0] m_prev;
  // requests one cycle back for cause attribution
  logic [PowerDomains-1:0] m_sw_d;
  logic [PowerDomains-1:0] m_hw_d;
  rst_info_t               m_info;

  // remaining cycles of the current scan phase
  int                      scan_left;
  bit                      sat_seen;

  // failures counted by the bound assertions
  int                      assert_fails;

  always #(ClkPeriod / 2) clk = ~clk;

  rst_mgr_top #(
    .PowerDomains  (PowerDomains)
  ) rst_mgr_top_inst (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .cmd_valid_i   (cmd_valid),
    .cmd_op_i      (cmd_op),
    .cmd_domain_i  (cmd_domain),
    .hw_req_i      (hw_req),
    .rst_parent_ni (rst_parent_n),
    .scanmode_i    (scanmode),
    .scan_rst_ni   (scan_rst_n),
    .rst_no        (dut_rst_n),
    .info_o        (dut_info)
  );

  bind rst_domain_ctrl rst_mgr_properties #(
    .PowerDomains (PowerDomains)
  ) rst_mgr_properties_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .scanmode_i   (scanmode_i),
    .scan_rst_ni  (scan_rst_ni),
    .rst_no       (rst_no),
    .dom_rst_no   (dom_rst_no)
  );

  assign assert_fails =
    rst_mgr_top_inst.rst_domain_ctrl_inst.rst_mgr_properties_inst.fail_cnt;

  task automatic check_val(input logic [31:0] exp_val, input logic [31:0] act_val,
                           input string what);
    if (exp_val !== act_val) begin
      $display("Fail at %0d ns: %s expected %0h got %0h", $time, what, exp_val, act_val);
      $display("Result: FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // one clock edge of the reference model with inputs as seen before the edge
  task automatic model_step();
    logic [PowerDomains-1:0] fall;
    logic [PowerDomains-1:0] want_up;
    logic [PowerDomains-1:0] nxt_dom;
    logic [PowerDomains-1:0] nxt_sw;
    rst_info_t               nxt_info;
    if (!rst_n) begin
      m_sw_d = m_sw;
      m_hw_d = m_hw;
      m_sw   = '0;
      m_hw   = '0;
      m_clr  = 1'b0;
      m_meta = '0;
      m_sync = '0;
      m_dom  = '0;
      m_prev = '0;
      m_info = '0;
    end else begin
      // result stage where an event beats a pending clear
      fall     = m_prev & ~m_dom;
      nxt_info = m_info;
      if (|fall) begin
        nxt_info.sw_seen     = m_info.sw_seen | (|(fall & m_sw_d));
        nxt_info.hw_seen     = m_info.hw_seen | (|(fall & ~m_sw_d & m_hw_d));
        nxt_info.parent_seen = m_info.parent_seen | (|(fall & ~m_sw_d & ~m_hw_d));
        if (m_info.count != 8'hff) begin
          nxt_info.count = m_info.count + 8'd1;
        end
      end else if (m_clr) begin
        nxt_info = '0;
      end
      // released parent and no hold of either kind
      want_up = m_sync & ~m_sw & ~m_hw;
      // off domains only follow while domain 0 is up
      nxt_dom = m_dom[DomainAonSel] ? want_up : '0;
      nxt_dom[DomainAonSel] = want_up[DomainAonSel];
      // sticky software hold
      nxt_sw = m_sw;
      if (cmd_valid && (int'(cmd_domain) < PowerDomains)) begin
        if (cmd_op == op_assert) begin
          nxt_sw[cmd_domain] = 1'b1;
        end else if (cmd_op == op_release) begin
          nxt_sw[cmd_domain] = 1'b0;
        end
      end
      m_sw_d = m_sw;
      m_hw_d = m_hw;
      m_prev = m_dom;
      m_dom  = nxt_dom;
      m_sync = m_meta;
      m_meta = rst_parent_n;
      m_sw   = nxt_sw;
      m_hw   = hw_req;
      m_clr  = cmd_valid && (cmd_op == op_clear_info);
      m_info = nxt_info;
    end
  endtask

  task automatic compare_outputs();
    logic [PowerDomains-1:0] exp_rst;
    // scan mux on top of the functional levels
    exp_rst = scanmode ? {PowerDomains{scan_rst_n}} : m_dom;
    check_val(32'(exp_rst), 32'(dut_rst_n), "rst_no");
    check_val({29'd0, m_info.sw_seen, m_info.hw_seen, m_info.parent_seen},
              {29'd0, dut_info.sw_seen, dut_info.hw_seen, dut_info.parent_seen},
              "info_o cause flags");
    check_val(32'(m_info.count), 32'(dut_info.count), "info_o count");
  endtask

  task automatic drive_random(input bit allow_clear);
    int unsigned             pick;
    logic [PowerDomains-1:0] hw_bits;
    logic [PowerDomains-1:0] par_bits;
    hw_bits  = '0;
    par_bits = '1;
    // short hardware pulses and parent dips per domain
    for (int i = 0; i < PowerDomains; i++) begin
      if ($urandom_range(31) == 0) begin
        hw_bits[i] = 1'b1;
      end
      if ($urandom_range(47) == 0) begin
        par_bits[i] = 1'b0;
      end
    end
    hw_req       <= hw_bits;
    rst_parent_n <= par_bits;
    // index covers 0..7 and the upper half must be ignored
    cmd_valid  <= ($urandom_range(1) == 0);
    cmd_domain <= DomainIdxW'($urandom_range(7));
    pick = $urandom_range(15);
    if (pick < 7) begin
      cmd_op <= op_assert;
    end else if (pick < 14) begin
      cmd_op <= op_release;
    end else if ((pick == 15) && allow_clear) begin
      cmd_op <= op_clear_info;
    end else begin
      cmd_op <= op_nop;
    end
    // occasional scan phase of 4 to 11 cycles
    if ((scan_left == 0) && ($urandom_range(127) == 0)) begin
      scan_left = $urandom_range(11, 4);
    end
    if (scan_left > 0) begin
      scan_left--;
      scanmode   <= 1'b1;
      scan_rst_n <= 1'($urandom_range(1));
    end else begin
      scanmode   <= 1'b0;
      scan_rst_n <= 1'b1;
    end
  endtask

  task automatic drive_idle();
    cmd_valid    <= 1'b0;
    cmd_op       <= op_nop;
    hw_req       <= '0;
    rst_parent_n <= '1;
    scanmode     <= 1'b0;
    scan_rst_n   <= 1'b1;
  endtask

  initial begin
    void'($urandom(Seed));
    // root reset on with everything else quiet and parents released
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd_op       = op_nop;
    cmd_domain   = '0;
    hw_req       = '0;
    rst_parent_n = '1;
    scanmode     = 1'b0;
    scan_rst_n   = 1'b1;
    m_sw         = '0;
    m_hw         = '0;
    m_clr        = 1'b0;
    m_meta       = '0;
    m_sync       = '0;
    m_dom        = '0;
    m_prev       = '0;
    m_sw_d       = '0;
    m_hw_d       = '0;
    m_info       = '0;
    scan_left    = 0;
    sat_seen     = 1'b0;
    for (int cyc = 0; cyc < TotalCycles; cyc++) begin
      @(posedge clk);
      model_step();
      if (m_info.count == 8'hff) begin
        sat_seen = 1'b1;
      end
      if (cyc == ResetCycles - 1) begin
        rst_n <= 1'b1;
      end else if (cyc >= TotalCycles - DrainCycles) begin
        drive_idle();
      end else if (cyc >= ResetCycles) begin
        drive_random(cyc >= ResetCycles + SatCycles);
      end
      // outputs settle well before the falling edge
      @(negedge clk);
      compare_outputs();
      check_val(32'd0, 32'(assert_fails), "bound assertion failures");
    end
    check_val(32'd1, 32'(sat_seen), "count saturation at 255");
    $display("Result: PASSED");
    $finish;
  end

  // watchdog
  initial begin
    #(WatchdogNs);
    $display("Error: test timed out after %0d ns without finishing", WatchdogNs);
    $display("Result: FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* all.f */
src/rst_mgr_pkg.sv
src/rst_req_decode.sv
src/rst_domain_ctrl.sv
src/rst_info_capture.sv
src/rst_mgr_top.sv
tb/rst_mgr_properties.sv
tb/rst_mgr_tb.sv

/* Bender.yml */
package:
  name: rst_mgr

sources:
  # package before its users
  - src/rst_mgr_pkg.sv
  - src/rst_req_decode.sv
  - src/rst_domain_ctrl.sv
  - src/rst_info_capture.sv
  - src/rst_mgr_top.sv

  # simulation only
  - target: test
    files:
      - tb/rst_mgr_properties.sv
      - tb/rst_mgr_tb.sv
